// ==== plru_stim.txt ====
# group op addr wdata expected_prdata expected_pslverr, all values hex except group and pslverr
# victim word is {valid, way[2:0]}, touch word is {way[6:4], set[3:0]}
1 R 00 00000000 00000000 0
1 R 0C 00000000 00000008 0
1 W 08 0000000F 00000000 0
1 R 0C 00000000 00000008 0
2 W 08 00000001 00000000 0
2 W 04 00000001 00000000 0
2 R 0C 00000000 0000000C 0
2 W 04 00000011 00000000 0
2 W 04 00000021 00000000 0
2 W 04 00000031 00000000 0
2 R 0C 00000000 0000000C 0
2 W 04 00000041 00000000 0
2 R 0C 00000000 00000008 0
2 W 04 00000051 00000000 0
2 W 04 00000061 00000000 0
2 W 04 00000071 00000000 0
2 R 0C 00000000 00000008 0
2 W 08 00000002 00000000 0
2 W 04 00000032 00000000 0
2 W 04 00000002 00000000 0
2 W 04 00000042 00000000 0
2 W 04 00000062 00000000 0
2 R 0C 00000000 0000000A 0
3 W 00 00000004 00000000 0
3 R 0C 00000000 0000000B 0
3 W 00 0000000C 00000000 0
3 R 0C 00000000 00000009 0
3 W 00 0000000F 00000000 0
3 R 0C 00000000 0000000D 0
3 W 00 00000000 00000000 0
4 W 08 00000003 00000000 0
4 W 00 000000FF 00000000 0
4 R 0C 00000000 00000007 0
4 W 00 00000000 00000000 0
4 W 04 00000006 00000000 0
4 W 04 00000046 00000000 0
4 W 04 00000015 00000000 0
4 W 08 00000006 00000000 0
4 R 0C 00000000 0000000A 0
5 W 10 DEADBEEF 00000000 1
5 R 10 00000000 00000000 1
5 W 0C 000000FF 00000000 1
5 R 00 00000000 00000000 0
5 R 08 00000000 00000006 0
5 R 0C 00000000 0000000A 0

// ==== plru.f ====
plru_pkg.sv
plru_if.sv
plru_backup.sv
plru_update.sv
plru_victim.sv
plru_core.sv
plru_apb_regs.sv
plru_top.sv
tb_plru.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the PLRU testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_plru -f plru.f -o tb_plru_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_plru_sim > sim.log 2>&1 || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; } || echo "Simulation passed"

// ==== tb_plru.sv ====
/* Testbench for the PLRU replacement selector
   Replays APB transfers from plru_stim.txt, checks prdata and pslverr */

`timescale 1ns/100ps

module tb_plru import plru_pkg::*; ();

  localparam int clk_period    = 100;
  localparam int reset_cycles  = 16;
  localparam int margin_cycles = 50;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // Stimulus table, one entry per APB transfer
  int          grp_q[$];
  logic        wr_q[$];
  logic [7:0]  addr_q[$];
  logic [31:0] wdata_q[$];
  logic [31:0] exp_q[$];
  logic        err_q[$];

  int          cycles;
  int          cycle_limit;   // Zero until the table is loaded
  int          checks;
  int          errors;
  int          grp_checks;
  int          grp_errors;
  apb_state_t  drv_phase;     // Driver phase, named in phase checks

  plru_top u_plru_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  // Stop a run that never reaches its end
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: run stopped after %0d clock cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task check_value(input logic [31:0] actual, input logic [31:0] expected, input string what);
    checks++;
    grp_checks++;
    if (actual !== expected) begin
      errors++;
      grp_errors++;
      $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  function string group_name(input int g);
    case (g)
      1:       group_name = "reset values";
      2:       group_name = "touch updates";
      3:       group_name = "backup walk";
      4:       group_name = "all disabled and set independence";
      5:       group_name = "slave errors";
      default: group_name = "unnamed";
    endcase
  endfunction

  task report_group(input int g);
    $display("Group %0d, %s: %0d checks, %0d errors", g, group_name(g), grp_checks, grp_errors);
    grp_checks = 0;
    grp_errors = 0;
  endtask

  // Columns: group, op, address, write data, expected read data, expected pslverr
  task load_stimulus(output bit ok);
    int          fd;
    int          got;
    int          g;
    int          e;
    string       line;
    string       op;
    logic [7:0]  a;
    logic [31:0] wd;
    logic [31:0] rd;
    fd = $fopen("plru_stim.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        got = $fgets(line, fd);
        // Comment and blank lines do not scan as six fields
        if (got > 0 && $sscanf(line, "%d %s %h %h %h %d", g, op, a, wd, rd, e) == 6) begin
          grp_q.push_back(g);
          wr_q.push_back(op == "W");
          addr_q.push_back(a);
          wdata_q.push_back(wd);
          exp_q.push_back(rd);
          err_q.push_back(e != 0);
        end
      end
      $fclose(fd);
    end
    ok = grp_q.size() > 0;
  endtask

  // One APB transfer, entered and left on a falling edge
  task apb_transfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                    output logic [31:0] rdata, output logic err);
    drv_phase = setup;
    psel      = 1'b1;
    penable   = 1'b0;
    pwrite    = write;
    paddr     = addr;
    pwdata    = wdata;
    #(clk_period/4);
    check_value(32'(pslverr), 32'(1'b0),
                $sformatf("pslverr in %s phase", drv_phase.name()));
    @(negedge clk);
    drv_phase = access;
    penable   = 1'b1;
    #(clk_period/4);              // Mid low phase, outputs settled
    check_value(32'(pready), 32'(1'b1),
                $sformatf("pready in %s phase", drv_phase.name()));
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    drv_phase = idle;
    psel      = 1'b0;
    penable   = 1'b0;
  endtask

  initial begin
    bit          loaded;
    logic [31:0] rdata;
    logic        err;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    drv_phase   = idle;
    cycles      = 0;
    cycle_limit = 0;
    checks      = 0;
    errors      = 0;
    grp_checks  = 0;
    grp_errors  = 0;
    void'($urandom(32'h67e9));  // Fixes the idle gap pattern
    load_stimulus(loaded);
    if (!loaded) begin
      $display("Could not read any transfers from plru_stim.txt");
      $display("Errors found");
      $finish;
    end else begin
      cycle_limit = 4 * grp_q.size() + reset_cycles + margin_cycles;
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < grp_q.size(); i++) begin
        if (i > 0 && grp_q[i] != grp_q[i-1]) report_group(grp_q[i-1]);
        apb_transfer(wr_q[i], addr_q[i], wdata_q[i], rdata, err);
        check_value(rdata, exp_q[i],
                    $sformatf("line %0d prdata at 0x%02h", i + 1, addr_q[i]));
        check_value(32'(err), 32'(err_q[i]),
                    $sformatf("line %0d pslverr at 0x%02h", i + 1, addr_q[i]));
        repeat ($urandom % 2) @(negedge clk);  // Idle gap of zero or one cycle
      end
      report_group(grp_q[grp_q.size()-1]);
      $display("Summary: %0d transfers, %0d checks, %0d errors", grp_q.size(), checks, errors);
      if (errors == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

// ==== plru_top.sv ====
/* PLRU replacement selector top
   APB slave pins, register block joined to the replacement core */

`timescale 1ns/100ps

module plru_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,   // Tied high inside
  output logic        pslverr
);

  plru_if u_bus ();  // Touch and victim link

  // Software facing side
  plru_apb_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .bus     (u_bus.regs)
  );

  // LRU table and victim logic
  plru_core u_core (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (u_bus.core)
  );

endmodule

// ==== plru_apb_regs.sv ====
/* APB register block for the PLRU selector
   Disable and set-select registers, touch pulse, victim readback */

`timescale 1ns/100ps

module plru_apb_regs import plru_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  plru_if.regs        bus
);

  apb_state_t         phase;       // Phase of the current cycle
  apb_state_t         prev_phase;  // Phase one cycle back
  logic               acc;         // Valid access cycle
  logic               wr;
  logic               rd;
  logic               hit_disable;
  logic               hit_touch;
  logic               hit_vsel;
  logic               hit_victim;
  logic               unmapped;
  logic [ways-1:0]    disable_q;
  logic [lg_sets-1:0] vsel_q;
  logic               touch_valid_q;
  logic [lg_sets-1:0] touch_set_q;
  logic [lg_ways-1:0] touch_way_q;
  logic [31:0]        rd_word;

  // Phase from the bus pins
  always_comb begin
    if (!psel)        phase = idle;
    else if (penable) phase = access;
    else              phase = setup;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) prev_phase <= idle;
    else        prev_phase <= phase;
  end

  assign acc = (phase == access) && (prev_phase == setup);
  assign wr  = acc && pwrite;
  assign rd  = acc && !pwrite;

  // Address decode
  assign hit_disable = paddr == addr_disable;
  assign hit_touch   = paddr == addr_touch;
  assign hit_vsel    = paddr == addr_vsel;
  assign hit_victim  = paddr == addr_victim;
  assign unmapped    = !(hit_disable || hit_touch || hit_vsel || hit_victim);

  // Bad address, or a write to the read-only victim word
  assign pslverr = acc && (unmapped || (pwrite && hit_victim));
  assign pready  = 1'b1;  // No wait states

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      disable_q     <= '0;
      vsel_q        <= '0;
      touch_valid_q <= 1'b0;
    end else begin
      if (wr && hit_disable) disable_q <= pwdata[ways-1:0];
      if (wr && hit_vsel)    vsel_q    <= pwdata[lg_sets-1:0];
      touch_valid_q <= wr && hit_touch;  // Pulse the cycle after access
    end
  end

  // Touch payload, qualified by the pulse
  always_ff @(posedge clk) begin
    if (wr && hit_touch) begin
      touch_set_q <= pwdata[lg_sets-1:0];
      touch_way_q <= pwdata[touch_way_lsb +: lg_ways];
    end
  end

  // Read mux, touch reads back as zero
  always_comb begin
    rd_word = '0;
    if (hit_disable)     rd_word = 32'(disable_q);
    else if (hit_vsel)   rd_word = 32'(vsel_q);
    else if (hit_victim) rd_word = 32'({bus.victim_valid, bus.victim_way});
  end

  assign prdata = rd ? rd_word : '0;  // Driven only in the access cycle

  assign bus.touch_valid   = touch_valid_q;
  assign bus.touch_set     = touch_set_q;
  assign bus.touch_way     = touch_way_q;
  assign bus.vsel_set      = vsel_q;
  assign bus.disabled_ways = disable_q;

  // Access only ever follows its own setup cycle
  a_penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel && (prev_phase == setup));

endmodule

// ==== plru_core.sv ====
/* Replacement core
   Per-set tree table, touch update and backup-aware victim selection */

`timescale 1ns/100ps

module plru_core import plru_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  plru_if.core bus
);

  logic [tree_bits-1:0] lru_tbl [sets];  // Tree bits of every set
  logic [tree_bits-1:0] touched_bits;    // Touched set after update
  logic [tree_bits-1:0] modify_mask;
  logic [tree_bits-1:0] modify_data;

  // Next tree for the set being touched
  plru_update u_update (
    .lru_bits  (lru_tbl[bus.touch_set]),
    .touch_way (bus.touch_way),
    .new_bits  (touched_bits)
  );

  // Overrides are the same for all sets, mask is global
  plru_backup u_backup (
    .disabled_ways (bus.disabled_ways),
    .modify_mask   (modify_mask),
    .modify_data   (modify_data)
  );

  // Victim of the queried set, combinational from the table
  plru_victim u_victim (
    .lru_bits      (lru_tbl[bus.vsel_set]),
    .modify_mask   (modify_mask),
    .modify_data   (modify_data),
    .disabled_ways (bus.disabled_ways),
    .victim_way    (bus.victim_way),
    .victim_valid  (bus.victim_valid)
  );

  // All trees start pointing at way 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < sets; s++) lru_tbl[s] <= '0;
    end else if (bus.touch_valid) begin
      lru_tbl[bus.touch_set] <= touched_bits;  // One set per cycle
    end
  end

  // Backup walk must never land on a disabled way
  a_victim_enabled: assert property (@(posedge clk) disable iff (!rst_n)
    bus.victim_valid |-> !bus.disabled_ways[bus.victim_way]);

  // APB spacing keeps touches at least two cycles apart
  a_touch_spaced: assert property (@(posedge clk) disable iff (!rst_n)
    bus.touch_valid |=> !bus.touch_valid);

endmodule

// ==== plru_victim.sv ====
/* Pseudo-LRU victim decoder
   Merges backup overrides into the tree and walks it down to a way */

`timescale 1ns/100ps

module plru_victim import plru_pkg::*; (
  input  logic [tree_bits-1:0] lru_bits,
  input  logic [tree_bits-1:0] modify_mask,
  input  logic [tree_bits-1:0] modify_data,
  input  logic [ways-1:0]      disabled_ways,
  output logic [lg_ways-1:0]   victim_way,
  output logic                 victim_valid
);

  logic [tree_bits-1:0] merged;     // Tree that only leads to enabled ways
  logic [lg_ways-1:0]   walk_way;

  // Forced bits win wherever the backup finder asks for it
  assign merged = (lru_bits & ~modify_mask) | (modify_data & modify_mask);

  // Descend one rank per step, each bit is one way index bit
  always_comb begin
    int unsigned node;
    node     = 0;
    walk_way = '0;
    for (int r = 0; r < lg_ways; r++) begin
      walk_way[lg_ways-1-r] = merged[node];
      node = 2*node + 1 + int'(merged[node]);  // Left child 2n+1, right 2n+2
    end
  end

  assign victim_way   = walk_way;
  assign victim_valid = ~&disabled_ways;  // Nothing to pick if all are off

endmodule

// ==== plru_update.sv ====
/* Pseudo-LRU touch update
   Points every node on the path of the touched way away from that way */

`timescale 1ns/100ps

module plru_update import plru_pkg::*; (
  input  logic [tree_bits-1:0] lru_bits,   // Current bits of the set
  input  logic [lg_ways-1:0]   touch_way,
  output logic [tree_bits-1:0] new_bits    // Bits after the touch
);

  // Way index MSB picks the root branch, LSB the leaf branch
  for (genvar r = 0; r < lg_ways; r++) begin : g_rank
    for (genvar k = 0; k < (1 << r); k++) begin : g_node

      logic on_path;  // Node lies between root and the touched way

      // Upper r bits of the way name the node within this rank
      assign on_path = (touch_way >> (lg_ways - r)) == lg_ways'(k);

      // Way in left subtree gives 1, right subtree gives 0
      assign new_bits[(1 << r)-1+k] = on_path ? ~touch_way[lg_ways-1-r]
                                              : lru_bits[(1 << r)-1+k];
    end
  end

endmodule

// ==== plru_backup.sv ====
/* Backup finder for the pseudo-LRU tree
   Marks tree nodes whose LRU side is fully disabled and says which way to force */

`timescale 1ns/100ps

module plru_backup import plru_pkg::*; (
  input  logic [ways-1:0]      disabled_ways,
  output logic [tree_bits-1:0] modify_mask,  // 1 = override the stored bit
  output logic [tree_bits-1:0] modify_data   // Forced direction, 1 = right
);

  // Rank r holds 2**r nodes, starting at node (2**r)-1
  for (genvar r = 0; r < lg_ways; r++) begin : g_rank

    // One flag per child subtree of this rank
    logic [(2 << r)-1:0] all_off;

    // Child subtree b covers ways/(2<<r) neighbouring ways
    for (genvar b = 0; b < (2 << r); b++) begin : g_bucket
      assign all_off[b] = &disabled_ways[b*(ways/(2 << r)) +: (ways/(2 << r))];
    end

    for (genvar k = 0; k < (1 << r); k++) begin : g_node
      // Left side dead, so steer right; otherwise steer left
      assign modify_data[(1 << r)-1+k] = all_off[2*k];
      // Override only where one side has nothing left to offer
      assign modify_mask[(1 << r)-1+k] = |all_off[2*k +: 2];
    end

  end

endmodule

// ==== plru_if.sv ====
/* Register block to replacement core link
   Touch requests and victim query travel down, the victim comes back */

`timescale 1ns/100ps

interface plru_if import plru_pkg::*; ();

  logic               touch_valid;    // Single cycle pulse
  logic [lg_sets-1:0] touch_set;
  logic [lg_ways-1:0] touch_way;
  logic [lg_sets-1:0] vsel_set;       // Set under victim query
  logic [ways-1:0]    disabled_ways;  // Global mask, 1 = never pick
  logic [lg_ways-1:0] victim_way;
  logic               victim_valid;   // Low when all ways are off

  modport regs (
    output touch_valid, touch_set, touch_way, vsel_set, disabled_ways,
    input  victim_way, victim_valid
  );

  modport core (
    input  touch_valid, touch_set, touch_way, vsel_set, disabled_ways,
    output victim_way, victim_valid
  );

endinterface

// ==== plru_pkg.sv ====
/* PLRU shared definitions
   Cache geometry, APB register map and bus phase type */

package plru_pkg;

  // Cache geometry
  localparam int ways      = 8;                // Ways per set, power of two
  localparam int lg_ways   = $clog2(ways);     // Way index width
  localparam int sets      = 16;
  localparam int lg_sets   = $clog2(sets);     // Set index width
  localparam int tree_bits = ways - 1;         // One bit per internal tree node

  // APB register offsets
  localparam logic [7:0] addr_disable = 8'h00;  // Disabled ways mask, rw
  localparam logic [7:0] addr_touch   = 8'h04;  // Touch request, wo
  localparam logic [7:0] addr_vsel    = 8'h08;  // Victim set select, rw
  localparam logic [7:0] addr_victim  = 8'h0C;  // Victim way and valid, ro

  // Field positions inside the touch word
  localparam int touch_way_lsb = 4;             // Way sits above the set field

  // APB transfer phase
  typedef enum logic [1:0] {
    idle,    // psel low
    setup,   // psel high, penable low
    access   // psel and penable high
  } apb_state_t;

endpackage
